// ==== verilog/memSettings.svh ====
/* Scratchpad sizing shared by the packages and modules
   Word address width, word width and byte lanes per word */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// 1024 words
`define MEM_ADDR_W 10

// Bits per word
`define MEM_DATA_W 32

// Byte lanes per word
`define MEM_LANES 4

`endif

// ==== verilog/memDataPkg.sv ====
/* Data types of the scratchpad
   Word, byte lane and word address views */
`include "memSettings.svh"

package memDataPkg;

   // One byte lane
   typedef logic [7:0] memByte;

   // Word address into the RAM
   typedef logic [`MEM_ADDR_W-1:0] wordAddr;

   // One RAM word seen whole or as lanes
   typedef union packed {
      logic [`MEM_DATA_W-1:0] word;
      memByte [`MEM_LANES-1:0] lanes;   // Lane 0 is the LSB
   } memWord;

endpackage

// ==== verilog/memCtrlPkg.sv ====
/* Control types of the scratchpad
   Access size for the aligner, FSM state and word count for the copier */
`include "memSettings.svh"

package memCtrlPkg;

   // Load/store access width
   typedef enum logic [1:0] {
      sizeByte,
      sizeHalf,
      sizeWord
   } accessSize;

   // Copier FSM
   typedef enum logic [1:0] {
      cpIdle,
      cpRead,
      cpWrite
   } copyState;

   typedef logic [`MEM_ADDR_W:0] wordCount;   // Up to the full depth

endpackage

// ==== verilog/memPortIf.sv ====
/* One RAM port bundle
   Client drives the request side and the RAM returns the read word */
`timescale 1ns/100ps
`include "memSettings.svh"

interface memPortIf
   import memDataPkg::*;
   ();

   logic                  en;     // Access this cycle
   logic [`MEM_LANES-1:0] we;     // Per-lane write enables
   wordAddr               addr;
   memWord                din;
   memWord                dout;   // Old word, one edge later

   modport client (
      output en,
      output we,
      output addr,
      output din,
      input  dout
   );

   modport ram (
      input  en,
      input  we,
      input  addr,
      input  din,
      output dout
   );

endinterface

// ==== verilog/tdpRamBe.sv ====
/* True dual-port RAM with byte write enables
   Read-first on both ports, single clock */
`timescale 1ns/100ps
`include "memSettings.svh"

module tdpRamBe
   import memDataPkg::*;
   #(
   parameter int ADDR_W = `MEM_ADDR_W
   ) (
   input logic clkA,
   memPortIf.ram a,
   memPortIf.ram b
   );

   // Storage array, contents unknown at start
   memWord memArray [0:(2**ADDR_W)-1];

   // Port A
   always @(posedge clkA) begin
      if (a.en) begin
         for (int i = 0; i < `MEM_LANES; i++) begin
            if (a.we[i]) begin
               memArray[a.addr].lanes[i] <= a.din.lanes[i];
            end
         end
         a.dout <= memArray[a.addr];   // Old contents
      end
   end

   // Port B
   always @(posedge clkA) begin
      if (b.en) begin
         for (int i = 0; i < `MEM_LANES; i++) begin
            if (b.we[i]) begin
               memArray[b.addr].lanes[i] <= b.din.lanes[i];
            end
         end
         b.dout <= memArray[b.addr];   // Old contents
      end
   end

endmodule

// ==== verilog/loadStoreAligner.sv ====
/* Load/store aligner on RAM port A
   Places sub-word stores into lanes and extends sub-word loads */
`timescale 1ns/100ps
`include "memSettings.svh"

module loadStoreAligner
   import memDataPkg::*;
   import memCtrlPkg::*;
   (
   input  logic                    clkA,
   input  logic                    rstN,
   input  logic                    lsReq,
   input  logic                    lsWrite,
   input  accessSize               lsSize,
   input  logic                    lsSigned,
   input  logic [`MEM_ADDR_W+1:0]  lsAddr,    // Byte address
   input  logic [`MEM_DATA_W-1:0]  lsWdata,
   output logic [`MEM_DATA_W-1:0]  lsRdata,
   output logic                    lsRdValid,
   memPortIf.client                mem
   );

   logic [1:0]            byteOff;
   logic [`MEM_LANES-1:0] laneSel;
   memWord                wrWord;
   memWord                rdWord;

   // Load context held for the extraction cycle
   logic                  ldPend;
   accessSize             ldSize;
   logic                  ldSigned;
   logic [1:0]            ldOff;
   memByte                ldByte;
   logic [15:0]           ldHalf;
   logic [`MEM_DATA_W-1:0] ldData;

   assign byteOff      = lsAddr[1:0];
   assign wrWord.word  = lsWdata;
   assign rdWord       = mem.dout;

   // Lanes touched by the access
   always_comb begin
      laneSel = '0;
      case (lsSize)
         sizeByte: laneSel[byteOff] = 1'b1;
         sizeHalf: begin
            laneSel[{byteOff[1], 1'b0}] = 1'b1;   // Even offset only
            laneSel[{byteOff[1], 1'b1}] = 1'b1;
         end
         default: laneSel = '1;
      endcase
   end

   // Port A request
   always_comb begin
      mem.en   = lsReq;
      mem.addr = lsAddr[`MEM_ADDR_W+1:2];
      mem.we   = lsWrite ? laneSel : '0;
      for (int i = 0; i < `MEM_LANES; i++) begin
         case (lsSize)
            sizeByte: mem.din.lanes[i] = wrWord.lanes[0];       // Same byte everywhere
            sizeHalf: mem.din.lanes[i] = wrWord.lanes[i % 2];   // Halfword pairs
            default:  mem.din.lanes[i] = wrWord.lanes[i];
         endcase
      end
   end

   // Pick and extend the loaded part
   always_comb begin
      ldByte = rdWord.lanes[ldOff];
      ldHalf = rdWord.word[{ldOff[1], 4'b0000} +: 16];
      case (ldSize)
         sizeByte: ldData = {{(`MEM_DATA_W-8){ldSigned & ldByte[7]}}, ldByte};
         sizeHalf: ldData = {{(`MEM_DATA_W-16){ldSigned & ldHalf[15]}}, ldHalf};
         default:  ldData = rdWord.word;
      endcase
   end

   always_ff @(posedge clkA) begin
      if (!rstN) begin
         ldPend    <= 1'b0;
         lsRdValid <= 1'b0;
      end else begin
         ldPend    <= lsReq && !lsWrite;
         lsRdValid <= ldPend;   // Result one edge after the RAM read
      end
   end

   always_ff @(posedge clkA) begin
      if (lsReq && !lsWrite) begin
         ldSize   <= lsSize;
         ldSigned <= lsSigned;
         ldOff    <= byteOff;
      end
      lsRdata <= ldData;
   end

endmodule

// ==== verilog/blockCopier.sv ====
/* Block copier on RAM port B
   Moves a run of words forward, one read and one write cycle per word */
`timescale 1ns/100ps
`include "memSettings.svh"

module blockCopier
   import memDataPkg::*;
   import memCtrlPkg::*;
   (
   input  logic     clkA,
   input  logic     rstN,
   input  logic     cpStart,
   input  wordAddr  cpSrc,
   input  wordAddr  cpDst,
   input  wordCount cpLen,
   output logic     cpBusy,
   output logic     cpDone,
   memPortIf.client mem
   );

   copyState state;
   wordAddr  srcPtr;
   wordAddr  dstPtr;
   wordCount remain;   // Words still to move
   logic     startOk;

   // Starts while busy are ignored
   assign startOk = (state == cpIdle) && cpStart;
   assign cpBusy  = (state != cpIdle);

   always_ff @(posedge clkA) begin
      if (!rstN) begin
         state  <= cpIdle;
         cpDone <= 1'b0;
         remain <= '0;
      end else begin
         cpDone <= 1'b0;
         case (state)
            cpIdle: begin
               if (cpStart) begin
                  remain <= cpLen;
                  if (cpLen != '0) begin
                     state <= cpRead;
                  end else begin
                     cpDone <= 1'b1;   // Empty copy finishes at once
                  end
               end
            end
            cpRead: begin
               state <= cpWrite;
            end
            cpWrite: begin
               remain <= remain - 1'b1;
               if (remain == wordCount'(1)) begin
                  state  <= cpIdle;
                  cpDone <= 1'b1;
               end else begin
                  state <= cpRead;
               end
            end
            default: begin
               state <= cpIdle;
            end
         endcase
      end
   end

   // Pointers, loaded on start and stepped after each write
   always_ff @(posedge clkA) begin
      if (startOk) begin
         srcPtr <= cpSrc;
         dstPtr <= cpDst;
      end else if (state == cpWrite) begin
         srcPtr <= srcPtr + 1'b1;
         dstPtr <= dstPtr + 1'b1;
      end
   end

   // Port B request
   always_comb begin
      mem.en = (state == cpRead) || (state == cpWrite);
      if (state == cpWrite) begin
         mem.addr = dstPtr;
         mem.we   = '1;
      end else begin
         mem.addr = srcPtr;
         mem.we   = '0;   // Read only
      end
      mem.din = mem.dout;   // Word read in the previous cycle
   end

endmodule

// ==== verilog/sharedMemTop.sv ====
/* Shared scratchpad top level
   Dual-port RAM with the load/store aligner on port A and the copier on port B */
`timescale 1ns/100ps
`include "memSettings.svh"

module sharedMemTop
   import memCtrlPkg::*;
   (
   input  logic                   clkA,
   input  logic                   rstN,

   // Load/store side
   input  logic                   lsReq,
   input  logic                   lsWrite,
   input  accessSize              lsSize,
   input  logic                   lsSigned,
   input  logic [`MEM_ADDR_W+1:0] lsAddr,
   input  logic [`MEM_DATA_W-1:0] lsWdata,
   output logic [`MEM_DATA_W-1:0] lsRdata,
   output logic                   lsRdValid,

   // Copier side
   input  logic                   cpStart,
   input  logic [`MEM_ADDR_W-1:0] cpSrc,
   input  logic [`MEM_ADDR_W-1:0] cpDst,
   input  logic [`MEM_ADDR_W:0]   cpLen,   // Count of words
   output logic                   cpBusy,
   output logic                   cpDone
   );

   memPortIf portA ();
   memPortIf portB ();

   tdpRamBe #(
      .ADDR_W (`MEM_ADDR_W)
   ) ram (
      .clkA (clkA),
      .a    (portA.ram),
      .b    (portB.ram)
   );

   loadStoreAligner aligner (
      .clkA      (clkA),
      .rstN      (rstN),
      .lsReq     (lsReq),
      .lsWrite   (lsWrite),
      .lsSize    (lsSize),
      .lsSigned  (lsSigned),
      .lsAddr    (lsAddr),
      .lsWdata   (lsWdata),
      .lsRdata   (lsRdata),
      .lsRdValid (lsRdValid),
      .mem       (portA.client)
   );

   blockCopier copier (
      .clkA    (clkA),
      .rstN    (rstN),
      .cpStart (cpStart),
      .cpSrc   (cpSrc),
      .cpDst   (cpDst),
      .cpLen   (cpLen),
      .cpBusy  (cpBusy),
      .cpDone  (cpDone),
      .mem     (portB.client)
   );

endmodule

// ==== tb/sharedMemTb.sv ====
/* Testbench for the shared scratchpad
   Random load/store and block copy traffic checked against a byte-level memory model */
`timescale 1ns/100ps
`include "memSettings.svh"

module sharedMemTb
   import memCtrlPkg::*;
   ();

   localparam int NUM_WORDS    = 1 << `MEM_ADDR_W;
   localparam int NUM_BYTES    = NUM_WORDS * `MEM_LANES;
   localparam int RESET_CYCLES = 4;
   localparam int N_WORD_OPS   = 48;
   localparam int N_SUB_STORES = 64;
   localparam int N_SUB_LOADS  = 96;
   localparam int N_COPIES     = 3;
   localparam int MAX_COPY     = 32;
   localparam int MAX_OVERLAP  = 16;
   // Port A operations, then copy words (two cycles each), then slack
   localparam int LS_OPS       = NUM_WORDS + 2 * N_WORD_OPS + 2 * N_SUB_STORES + N_SUB_LOADS
                                 + (N_COPIES + 1) * MAX_COPY + MAX_OVERLAP + 2;
   localparam int COPY_WORDS   = (N_COPIES + 1) * MAX_COPY + MAX_OVERLAP;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + LS_OPS + 2 * COPY_WORDS + 64;

   logic                   clkA = 1'b0;
   logic                   rstN;
   logic                   lsReq;
   logic                   lsWrite;
   accessSize              lsSize;
   logic                   lsSigned;
   logic [`MEM_ADDR_W+1:0] lsAddr;
   logic [`MEM_DATA_W-1:0] lsWdata;
   logic [`MEM_DATA_W-1:0] lsRdata;
   logic                   lsRdValid;
   logic                   cpStart;
   logic [`MEM_ADDR_W-1:0] cpSrc;
   logic [`MEM_ADDR_W-1:0] cpDst;
   logic [`MEM_ADDR_W:0]   cpLen;
   logic                   cpBusy;
   logic                   cpDone;

   logic [7:0]  modelMem [0:NUM_BYTES-1];   // Byte address indexes it directly
   logic        pendValid1;                 // Load issued last cycle
   logic        pendValid2;                 // Result due this cycle
   logic [31:0] pendData1;
   logic [31:0] pendData2;
   logic        copyWatch;
   int          busyCycles;
   int          copyLen;
   logic [31:0] lcgState = 32'd60903;
   int          cycleCount = 0;

   sharedMemTop uut (.*);

   always #2 clkA = ~clkA;   // 4 ns period

   always @(posedge clkA) begin
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("Simulation FAILED");
         $fatal(1, "Timeout");
      end
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Upper bits only, the low LCG bits repeat quickly
   function automatic int randBelow(int n);
      logic [31:0] r;
      r = nextRand();
      return int'(r[31:8]) % n;
   endfunction

   function automatic logic randBit();
      return randBelow(2) == 1;
   endfunction

   function automatic accessSize randSubSize();
      return randBit() ? sizeHalf : sizeByte;
   endfunction

   function automatic void modelStore(accessSize size, int addr, logic [31:0] data);
      case (size)
         sizeByte: modelMem[addr] = data[7:0];
         sizeHalf: begin
            modelMem[addr & ~1]       = data[7:0];
            modelMem[(addr & ~1) + 1] = data[15:8];
         end
         default: begin
            for (int i = 0; i < 4; i++)
               modelMem[(addr & ~3) + i] = data[8*i +: 8];
         end
      endcase
   endfunction

   function automatic logic [31:0] modelLoad(accessSize size, logic sgn, int addr);
      logic [7:0]  b;
      logic [15:0] h;
      int          base;
      case (size)
         sizeByte: begin
            b = modelMem[addr];
            return {{24{sgn & b[7]}}, b};
         end
         sizeHalf: begin
            base = addr & ~1;
            h    = {modelMem[base + 1], modelMem[base]};
            return {{16{sgn & h[15]}}, h};
         end
         default: begin
            base = addr & ~3;
            return {modelMem[base + 3], modelMem[base + 2], modelMem[base + 1], modelMem[base]};
         end
      endcase
   endfunction

   // Word by word upward, so overlaps smear like a plain loop
   function automatic void modelCopy(int src, int dst, int len);
      for (int i = 0; i < len; i++) begin
         for (int l = 0; l < `MEM_LANES; l++)
            modelMem[4 * (dst + i) + l] = modelMem[4 * (src + i) + l];
      end
   endfunction

   task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] time %0t ns %s got %h expected %h", $time, name, actual, expected);
         $display("Simulation FAILED");
         $fatal(1, "Mismatch");
      end
   endtask

   // One falling edge, check what the last rising edge produced, clear strobes
   task automatic tick();
      @(negedge clkA);
      checkValue("lsRdValid", lsRdValid, pendValid2);
      if (pendValid2)
         checkValue("lsRdata", lsRdata, pendData2);
      pendValid2 = pendValid1;
      pendData2  = pendData1;
      pendValid1 = 1'b0;
      if (copyWatch) begin
         if (cpDone) begin
            checkValue("cpBusy", cpBusy, 1'b0);   // Falls with the done pulse
            checkValue("cpBusy cycle count", busyCycles, 2 * copyLen);
            copyWatch = 1'b0;
         end else begin
            checkValue("cpBusy", cpBusy, 1'b1);
            busyCycles++;
         end
      end else begin
         checkValue("cpBusy", cpBusy, 1'b0);
         checkValue("cpDone", cpDone, 1'b0);
      end
      lsReq   = 1'b0;
      lsWrite = 1'b0;
      cpStart = 1'b0;
   endtask

   task automatic storeOp(accessSize size, int addr, logic [31:0] data);
      tick();
      lsReq    = 1'b1;
      lsWrite  = 1'b1;
      lsSize   = size;
      lsSigned = 1'b0;
      lsAddr   = addr[`MEM_ADDR_W+1:0];
      lsWdata  = data;
      modelStore(size, addr, data);
   endtask

   task automatic loadOp(accessSize size, logic sgn, int addr);
      tick();
      lsReq      = 1'b1;
      lsWrite    = 1'b0;
      lsSize     = size;
      lsSigned   = sgn;
      lsAddr     = addr[`MEM_ADDR_W+1:0];
      lsWdata    = nextRand();   // Ignored on loads
      pendValid1 = 1'b1;
      pendData1  = modelLoad(size, sgn, addr);
   endtask

   task automatic startCopy(int src, int dst, int len);
      tick();
      cpStart    = 1'b1;
      cpSrc      = src[`MEM_ADDR_W-1:0];
      cpDst      = dst[`MEM_ADDR_W-1:0];
      cpLen      = len[`MEM_ADDR_W:0];
      modelCopy(src, dst, len);
      copyWatch  = 1'b1;
      busyCycles = 0;
      copyLen    = len;
   endtask

   task automatic waitCopyDone();
      while (copyWatch)
         tick();
   endtask

   initial begin
      int addrList [$];
      int a;
      int src;
      int dst;
      int len;
      rstN       = 1'b0;
      lsReq      = 1'b0;
      lsWrite    = 1'b0;
      lsSize     = sizeWord;
      lsSigned   = 1'b0;
      lsAddr     = '0;
      lsWdata    = '0;
      cpStart    = 1'b0;
      cpSrc      = '0;
      cpDst      = '0;
      cpLen      = '0;
      pendValid1 = 1'b0;
      pendValid2 = 1'b0;
      pendData1  = '0;
      pendData2  = '0;
      copyWatch  = 1'b0;
      busyCycles = 0;
      copyLen    = 0;
      repeat (RESET_CYCLES) @(negedge clkA);
      rstN = 1'b1;

      // RAM powers up unknown, give every word a value
      for (int w = 0; w < NUM_WORDS; w++)
         storeOp(sizeWord, 4 * w, nextRand());

      for (int i = 0; i < N_WORD_OPS; i++) begin
         a = randBelow(NUM_BYTES);
         addrList.push_back(a);
         storeOp(sizeWord, a, nextRand());
      end
      foreach (addrList[i])
         loadOp(sizeWord, randBit(), addrList[i]);   // Back to back
      addrList.delete();

      // Sub-word stores, then whole-word view of the same words
      for (int i = 0; i < N_SUB_STORES; i++) begin
         a = randBelow(NUM_BYTES);
         addrList.push_back(a);
         storeOp(randSubSize(), a, nextRand());
      end
      foreach (addrList[i])
         loadOp(sizeWord, 1'b0, addrList[i]);
      addrList.delete();

      for (int i = 0; i < N_SUB_LOADS; i++)
         loadOp(randSubSize(), randBit(), randBelow(NUM_BYTES));

      // Low half into upper half
      for (int c = 0; c < N_COPIES; c++) begin
         len = 1 + randBelow(MAX_COPY);
         src = randBelow(NUM_WORDS / 2 - len + 1);
         dst = NUM_WORDS / 2 + randBelow(NUM_WORDS / 2 - len + 1);
         startCopy(src, dst, len);
         waitCopyDone();
         for (int i = 0; i < len; i++)
            loadOp(sizeWord, 1'b0, 4 * (dst + i));
      end

      // Port A traffic in the low quarter during an upper-half copy
      len = MAX_COPY / 2 + randBelow(MAX_COPY / 2 + 1);
      src = NUM_WORDS / 2 + randBelow(NUM_WORDS / 4 - len);
      dst = 3 * NUM_WORDS / 4 + randBelow(NUM_WORDS / 4 - len);
      startCopy(src, dst, len);
      while (copyWatch) begin
         a = randBelow(NUM_BYTES / 4);
         if (randBit())
            storeOp(randSubSize(), a, nextRand());
         else
            loadOp(randSubSize(), randBit(), a);
      end
      for (int i = 0; i < len; i++)
         loadOp(sizeWord, 1'b0, 4 * (dst + i));

      len = 2 + randBelow(MAX_OVERLAP - 1);   // Overlap, destination one word up
      src = NUM_WORDS / 2 + randBelow(NUM_WORDS / 2 - len - 1);
      startCopy(src, src + 1, len);
      waitCopyDone();
      for (int i = 0; i <= len; i++)
         loadOp(sizeWord, 1'b0, 4 * (src + i));

      src = randBelow(NUM_WORDS);
      dst = randBelow(NUM_WORDS);
      startCopy(src, dst, 0);   // Empty copy, done only
      waitCopyDone();
      loadOp(sizeWord, 1'b0, 4 * dst);

      repeat (3) tick();   // Drain the load pipeline
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/memDataPkg.sv
verilog/memCtrlPkg.sv
verilog/memPortIf.sv
verilog/tdpRamBe.sv
verilog/loadStoreAligner.sv
verilog/blockCopier.sv
verilog/sharedMemTop.sv
tb/sharedMemTb.sv
